//--- source/fc_consts.svh
`ifndef FC_CONSTS_SVH
`define FC_CONSTS_SVH

// Network sizes, all multiples of four
`define FC_X0_SIZE      16
`define FC_H_SIZE       8
`define FC_Y_SIZE       4
`define FC_LANES        4

// Accumulator scale relative to the int8 values
`define FC_RQ_SHIFT     6

// Registered read port
`define FC_MEM_LATENCY  1

// Memory depths in 32-bit words
`define FC_FEAT_DEPTH   16
`define FC_PARAM_DEPTH  64

// Feature memory map, hidden results go above the inputs
`define FC_HID_BASE     8

// Parameter memory map
`define FC_W0_BASE      0
`define FC_B0_BASE      32
`define FC_W1_BASE      34
`define FC_B1_BASE      42

`endif

//--- source/fc_pkg.sv
`include "fc_consts.svh"

package fc_pkg;

    // Quantized feature, weight, bias or score
    typedef logic signed [7:0] int8_t;

    // Lane 0 sits in the low byte and holds the lowest index
    typedef int8_t [`FC_LANES-1:0] quad_t;

    // Wide enough for the shifted bias plus sixteen full-scale products
    typedef logic signed [19:0] acc_t;

    // Word address for both memories and the load port
    typedef logic [7:0] addr_t;

    // Output class index
    typedef logic [3:0] class_t;

endpackage

//--- source/fc_if.sv
`timescale 1ns/100ps

// Operand beats from the fetch side into the MAC
interface fc_operand_if;
    logic          valid;
    logic          first;
    logic          last;
    logic          relu;
    fc_pkg::quad_t feature;
    fc_pkg::quad_t weight;
    // Only meaningful on the first beat of a neuron
    fc_pkg::int8_t bias;

    modport source (output valid, first, last, relu, feature, weight, bias);
    modport sink   (input  valid, first, last, relu, feature, weight, bias);
endinterface

// Neuron results, plus the writeback path that closes the loop to fetch
interface fc_result_if;
    logic          valid;
    fc_pkg::int8_t value;
    logic          wb_we;
    fc_pkg::addr_t wb_addr;
    fc_pkg::quad_t wb_data;
    logic          layer_done;

    modport mac   (output valid, value);
    modport sink  (input  valid, value,
                   output wb_we, wb_addr, wb_data, layer_done);
    modport fetch (input  wb_we, wb_addr, wb_data, layer_done);
endinterface

//--- source/sync_ram.sv
`timescale 1ns/100ps

module sync_ram #(
    parameter int DEPTH = 16
) (
    input  logic          clk,
    input  logic          we,
    input  fc_pkg::addr_t waddr,
    input  fc_pkg::addr_t raddr,
    input  fc_pkg::quad_t wdata,
    output fc_pkg::quad_t rdata
);
    localparam int AW = $clog2(DEPTH);

    fc_pkg::quad_t mem [DEPTH];

    // Registered read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[AW-1:0]] <= wdata;
        end
        rdata <= mem[raddr[AW-1:0]];
    end

endmodule

//--- source/fc_fetch.sv
`timescale 1ns/100ps
`include "fc_consts.svh"

module fc_fetch (
    input  logic          clk,
    input  logic          rstn,
    input  logic          load_we,
    input  logic          load_sel,
    input  fc_pkg::addr_t load_addr,
    input  fc_pkg::quad_t load_data,
    input  logic          r_valid,
    fc_operand_if.source  op,
    fc_result_if.fetch    res
);
    typedef enum logic [1:0] {S_IDLE, S_BIAS, S_ROW, S_WAIT} state_t;

    state_t        state;
    logic          layer;
    fc_pkg::addr_t neuron;
    fc_pkg::addr_t word;

    // Per-layer geometry
    fc_pkg::addr_t words;
    fc_pkg::addr_t neuron_last;
    fc_pkg::addr_t w_base;
    fc_pkg::addr_t b_base;
    fc_pkg::addr_t x_base;

    logic          issue_bias;
    logic          issue_row;
    logic          row_end;

    logic          host_feat;
    logic          feat_we;
    fc_pkg::addr_t feat_waddr;
    fc_pkg::quad_t feat_wdata;
    fc_pkg::addr_t feat_raddr;
    fc_pkg::quad_t feat_rdata;
    logic          param_we;
    fc_pkg::addr_t param_raddr;
    fc_pkg::quad_t param_rdata;

    // Read-side copies, one cycle behind the issue
    logic          bias_rd_q;
    logic [1:0]    lane_q;
    fc_pkg::int8_t bias_q;

    always_comb begin
        if (layer) begin
            words       = fc_pkg::addr_t'(`FC_H_SIZE / `FC_LANES);
            neuron_last = fc_pkg::addr_t'(`FC_Y_SIZE - 1);
            w_base      = fc_pkg::addr_t'(`FC_W1_BASE);
            b_base      = fc_pkg::addr_t'(`FC_B1_BASE);
            x_base      = fc_pkg::addr_t'(`FC_HID_BASE);
        end else begin
            words       = fc_pkg::addr_t'(`FC_X0_SIZE / `FC_LANES);
            neuron_last = fc_pkg::addr_t'(`FC_H_SIZE - 1);
            w_base      = fc_pkg::addr_t'(`FC_W0_BASE);
            b_base      = fc_pkg::addr_t'(`FC_B0_BASE);
            x_base      = '0;
        end
    end

    assign issue_bias = (state == S_BIAS);
    assign issue_row  = (state == S_ROW);
    assign row_end    = (word == words - 1'b1);

    // Four biases per word, lane picked by the neuron's low bits
    assign param_raddr = issue_bias ? b_base + (neuron >> 2)
                                    : w_base + neuron * words + word;
    assign feat_raddr  = x_base + word;

    // Host loads take the feature port over writeback
    assign host_feat  = load_we && !load_sel;
    assign feat_we    = host_feat || res.wb_we;
    assign feat_waddr = host_feat ? load_addr : res.wb_addr;
    assign feat_wdata = host_feat ? load_data : res.wb_data;
    assign param_we   = load_we && load_sel;

    sync_ram #(.DEPTH(`FC_FEAT_DEPTH)) feat_ram (
        .clk   (clk),
        .we    (feat_we),
        .waddr (feat_waddr),
        .raddr (feat_raddr),
        .wdata (feat_wdata),
        .rdata (feat_rdata)
    );

    sync_ram #(.DEPTH(`FC_PARAM_DEPTH)) param_ram (
        .clk   (clk),
        .we    (param_we),
        .waddr (load_addr),
        .raddr (param_raddr),
        .wdata (load_data),
        .rdata (param_rdata)
    );

    // Layer, neuron and word sequencing
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state  <= S_IDLE;
            layer  <= 1'b0;
            neuron <= '0;
            word   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (r_valid) begin
                        state  <= S_BIAS;
                        layer  <= 1'b0;
                        neuron <= '0;
                    end
                end
                S_BIAS: begin
                    state <= S_ROW;
                    word  <= '0;
                end
                S_ROW: begin
                    word <= word + 1'b1;
                    if (row_end) begin
                        word <= '0;
                        if (neuron == neuron_last) begin
                            neuron <= '0;
                            // Hidden layer must be written back before layer 1 reads it
                            state  <= layer ? S_IDLE : S_WAIT;
                        end else begin
                            neuron <= neuron + 1'b1;
                            state  <= S_BIAS;
                        end
                    end
                end
                S_WAIT: begin
                    if (res.layer_done) begin
                        layer <= 1'b1;
                        state <= S_BIAS;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Beat flags line up with the read data
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            op.valid  <= 1'b0;
            op.first  <= 1'b0;
            op.last   <= 1'b0;
            op.relu   <= 1'b0;
            bias_rd_q <= 1'b0;
        end else begin
            op.valid  <= issue_row;
            op.first  <= issue_row && (word == '0);
            op.last   <= issue_row && row_end;
            op.relu   <= !layer;
            bias_rd_q <= issue_bias;
        end
    end

    always_ff @(posedge clk) begin
        lane_q <= neuron[1:0];
        if (bias_rd_q) begin
            bias_q <= param_rdata[lane_q];
        end
    end

    assign op.feature = feat_rdata;
    assign op.weight  = param_rdata;
    assign op.bias    = bias_q;

endmodule

//--- source/fc_mac.sv
`timescale 1ns/100ps
`include "fc_consts.svh"

module fc_mac (
    input  logic       clk,
    input  logic       rstn,
    fc_operand_if.sink op,
    fc_result_if.mac   res
);
    fc_pkg::acc_t  acc;
    fc_pkg::acc_t  acc_start;
    fc_pkg::acc_t  acc_next;
    fc_pkg::acc_t  dot;
    fc_pkg::acc_t  scaled;
    fc_pkg::int8_t sat;
    fc_pkg::int8_t clipped;

    // Four lane products of the current beat
    always_comb begin
        dot = '0;
        for (int i = 0; i < `FC_LANES; i++) begin
            dot = dot + fc_pkg::acc_t'(op.feature[i]) * fc_pkg::acc_t'(op.weight[i]);
        end
    end

    // A new neuron starts from its bias at accumulator scale
    assign acc_start = op.first ? (fc_pkg::acc_t'(op.bias) <<< `FC_RQ_SHIFT) : acc;
    assign acc_next  = acc_start + dot;

    // Requantize back to int8
    assign scaled = acc_next >>> `FC_RQ_SHIFT;

    always_comb begin
        if (scaled > fc_pkg::acc_t'(127)) begin
            sat = 8'sd127;
        end else if (scaled < fc_pkg::acc_t'(-128)) begin
            sat = -8'sd128;
        end else begin
            sat = fc_pkg::int8_t'(scaled);
        end
    end

    // ReLU only on hidden neurons
    assign clipped = (op.relu && sat[7]) ? '0 : sat;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= op.valid && op.last;
        end
    end

    always_ff @(posedge clk) begin
        if (op.valid) begin
            acc <= acc_next;
            if (op.last) begin
                res.value <= clipped;
            end
        end
    end

endmodule

//--- source/fc_result_sink.sv
`timescale 1ns/100ps
`include "fc_consts.svh"

module fc_result_sink (
    input  logic           clk,
    input  logic           rstn,
    fc_result_if.sink      res,
    output fc_pkg::class_t out_data,
    output logic           t_valid
);
    // Result index within the run, hidden results first
    fc_pkg::addr_t  cnt;
    logic [1:0]     lane;
    logic           hidden;
    fc_pkg::quad_t  pack_q;
    fc_pkg::quad_t  pack_next;

    fc_pkg::class_t score_idx;
    fc_pkg::int8_t  best_val;
    fc_pkg::class_t best_idx;
    logic           better;
    logic           last_score;

    assign lane       = cnt[1:0];
    assign hidden     = cnt < fc_pkg::addr_t'(`FC_H_SIZE);
    assign score_idx  = fc_pkg::class_t'(cnt - fc_pkg::addr_t'(`FC_H_SIZE));
    assign last_score = !hidden && (score_idx == fc_pkg::class_t'(`FC_Y_SIZE - 1));

    // Strictly greater, so ties keep the lower index
    assign better = (score_idx == '0) || (res.value > best_val);

    always_comb begin
        pack_next       = pack_q;
        pack_next[lane] = res.value;
    end

    // Writeback on the cycle the fourth lane arrives
    assign res.wb_we      = res.valid && hidden && (lane == 2'd3);
    assign res.wb_addr    = fc_pkg::addr_t'(`FC_HID_BASE) + (cnt >> 2);
    assign res.wb_data    = pack_next;
    assign res.layer_done = res.valid && (cnt == fc_pkg::addr_t'(`FC_H_SIZE - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt      <= '0;
            t_valid  <= 1'b0;
            out_data <= '0;
        end else begin
            t_valid <= 1'b0;
            if (res.valid) begin
                if (last_score) begin
                    cnt      <= '0;
                    t_valid  <= 1'b1;
                    out_data <= better ? score_idx : best_idx;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid) begin
            if (hidden) begin
                pack_q <= pack_next;
            end else if (better) begin
                best_val <= res.value;
                best_idx <= score_idx;
            end
        end
    end

endmodule

//--- source/fc_top.sv
`timescale 1ns/100ps

module fc_top (
    input  logic           clk,
    input  logic           rstn,
    input  logic           load_we,
    input  logic           load_sel,
    input  fc_pkg::addr_t  load_addr,
    input  fc_pkg::quad_t  load_data,
    input  logic           r_valid,
    output fc_pkg::class_t out_data,
    output logic           t_valid
);
    fc_operand_if op_if ();
    fc_result_if  res_if ();

    // Memories and read sequencing
    fc_fetch fetch0 (
        .clk       (clk),
        .rstn      (rstn),
        .load_we   (load_we),
        .load_sel  (load_sel),
        .load_addr (load_addr),
        .load_data (load_data),
        .r_valid   (r_valid),
        .op        (op_if.source),
        .res       (res_if.fetch)
    );

    fc_mac mac0 (
        .clk  (clk),
        .rstn (rstn),
        .op   (op_if.sink),
        .res  (res_if.mac)
    );

    // Hidden writeback and argmax
    fc_result_sink sink0 (
        .clk      (clk),
        .rstn     (rstn),
        .res      (res_if.sink),
        .out_data (out_data),
        .t_valid  (t_valid)
    );

endmodule

//--- tb/fc_tb_model.svh
`ifndef FC_TB_MODEL_SVH
`define FC_TB_MODEL_SVH

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
endfunction

// One LFSR step per bit, low bit first
function automatic fc_pkg::int8_t rand_int8();
    fc_pkg::int8_t v;
    for (int i = 0; i < 8; i++) begin
        v[i] = lfsr_next_bit();
    end
    return v;
endfunction

// Scale back to int8, saturate, optional ReLU
function automatic fc_pkg::int8_t requant(input int acc, input bit relu);
    int s;
    s = acc >>> `FC_RQ_SHIFT;
    if (s > 127) begin
        s = 127;
    end else if (s < -128) begin
        s = -128;
    end
    if (relu && s < 0) begin
        s = 0;
    end
    return fc_pkg::int8_t'(s);
endfunction

// Expected class of the current network and inputs
function automatic fc_pkg::class_t model_class();
    fc_pkg::int8_t hid [`FC_H_SIZE];
    fc_pkg::int8_t score [`FC_Y_SIZE];
    int            acc;
    int            best;
    for (int n = 0; n < `FC_H_SIZE; n++) begin
        acc = int'(b0[n]) * (1 << `FC_RQ_SHIFT);
        for (int i = 0; i < `FC_X0_SIZE; i++) begin
            acc += int'(x0[i]) * int'(w0[n][i]);
        end
        hid[n] = requant(acc, 1'b1);
    end
    for (int c = 0; c < `FC_Y_SIZE; c++) begin
        acc = int'(b1[c]) * (1 << `FC_RQ_SHIFT);
        for (int i = 0; i < `FC_H_SIZE; i++) begin
            acc += int'(hid[i]) * int'(w1[c][i]);
        end
        score[c] = requant(acc, 1'b0);
    end
    // Ties keep the lower index
    best = 0;
    for (int c = 1; c < `FC_Y_SIZE; c++) begin
        if (score[c] > score[best]) begin
            best = c;
        end
    end
    return fc_pkg::class_t'(best);
endfunction

// Pack inputs and parameters into word images, four lanes per word
function automatic void build_images();
    for (int i = 0; i < `FC_X0_SIZE; i++) begin
        feat_img[i / `FC_LANES][i % `FC_LANES] = x0[i];
    end
    for (int a = 0; a < `FC_PARAM_DEPTH; a++) begin
        param_img[a] = '0;
    end
    for (int n = 0; n < `FC_H_SIZE; n++) begin
        param_img[`FC_B0_BASE + n / `FC_LANES][n % `FC_LANES] = b0[n];
        for (int i = 0; i < `FC_X0_SIZE; i++) begin
            param_img[`FC_W0_BASE + n * (`FC_X0_SIZE / `FC_LANES) + i / `FC_LANES]
                     [i % `FC_LANES] = w0[n][i];
        end
    end
    for (int c = 0; c < `FC_Y_SIZE; c++) begin
        param_img[`FC_B1_BASE + c / `FC_LANES][c % `FC_LANES] = b1[c];
        for (int i = 0; i < `FC_H_SIZE; i++) begin
            param_img[`FC_W1_BASE + c * (`FC_H_SIZE / `FC_LANES) + i / `FC_LANES]
                     [i % `FC_LANES] = w1[c][i];
        end
    end
endfunction

`endif

//--- tb/tb_fc_top.sv
`timescale 1ns/100ps
`include "fc_consts.svh"

module tb_fc_top;
    localparam int RUN_TIMEOUT = 500;
    localparam int WINDOW      = 400;

    logic           clk;
    logic           rstn;
    logic           load_we;
    logic           load_sel;
    fc_pkg::addr_t  load_addr;
    fc_pkg::quad_t  load_data;
    logic           r_valid;
    fc_pkg::class_t out_data;
    logic           t_valid;

    // Network under test and its memory images
    logic [31:0]    lfsr;
    fc_pkg::int8_t  x0 [`FC_X0_SIZE];
    fc_pkg::int8_t  w0 [`FC_H_SIZE][`FC_X0_SIZE];
    fc_pkg::int8_t  b0 [`FC_H_SIZE];
    fc_pkg::int8_t  w1 [`FC_Y_SIZE][`FC_H_SIZE];
    fc_pkg::int8_t  b1 [`FC_Y_SIZE];
    fc_pkg::quad_t  feat_img [`FC_X0_SIZE / `FC_LANES];
    fc_pkg::quad_t  param_img [`FC_PARAM_DEPTH];

    `include "fc_tb_model.svh"

    fc_top dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .load_we   (load_we),
        .load_sel  (load_sel),
        .load_addr (load_addr),
        .load_data (load_data),
        .r_valid   (r_valid),
        .out_data  (out_data),
        .t_valid   (t_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_class(input string name, input fc_pkg::class_t got,
                               input fc_pkg::class_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic load_word(input logic sel, input fc_pkg::addr_t addr,
                             input fc_pkg::quad_t data);
        @(posedge clk);
        load_we   <= 1'b1;
        load_sel  <= sel;
        load_addr <= addr;
        load_data <= data;
        @(posedge clk);
        load_we   <= 1'b0;
    endtask

    // Input words, then every parameter word up to the layer-1 biases
    task automatic load_net();
        build_images();
        for (int k = 0; k < `FC_X0_SIZE / `FC_LANES; k++) begin
            load_word(1'b0, fc_pkg::addr_t'(k), feat_img[k]);
        end
        for (int a = 0; a < `FC_B1_BASE + `FC_Y_SIZE / `FC_LANES; a++) begin
            load_word(1'b1, fc_pkg::addr_t'(a), param_img[a]);
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        r_valid <= 1'b1;
        @(posedge clk);
        r_valid <= 1'b0;
    endtask

    task automatic run_net(input fc_pkg::class_t exp);
        logic seen;
        int   cyc;
        seen = 1'b0;
        cyc  = 0;
        pulse_start();
        while (!seen && cyc < RUN_TIMEOUT) begin
            @(negedge clk);
            seen = t_valid;
            cyc++;
        end
        if (!seen) begin
            fail_run("No t_valid pulse arrived within the run timeout");
        end
        check_class("out_data", out_data, exp);
    endtask

    // Weights narrowed by a shift so that not every neuron saturates
    task automatic randomize_net(input int w0_shift, input int w1_shift);
        for (int i = 0; i < `FC_X0_SIZE; i++) begin
            x0[i] = rand_int8();
        end
        for (int n = 0; n < `FC_H_SIZE; n++) begin
            b0[n] = rand_int8();
            for (int i = 0; i < `FC_X0_SIZE; i++) begin
                w0[n][i] = rand_int8() >>> w0_shift;
            end
        end
        for (int c = 0; c < `FC_Y_SIZE; c++) begin
            b1[c] = rand_int8();
            for (int i = 0; i < `FC_H_SIZE; i++) begin
                w1[c][i] = rand_int8() >>> w1_shift;
            end
        end
    endtask

    task automatic test_idle();
        repeat (20) begin
            @(negedge clk);
            check_flag("t_valid", t_valid, 1'b0);
            check_class("out_data", out_data, '0);
        end
    endtask

    // Zero weights leave each score equal to its own bias
    task automatic test_bias_only(input fc_pkg::quad_t biases, input fc_pkg::class_t exp);
        randomize_net(0, 0);
        for (int n = 0; n < `FC_H_SIZE; n++) begin
            for (int i = 0; i < `FC_X0_SIZE; i++) begin
                w0[n][i] = '0;
            end
        end
        for (int c = 0; c < `FC_Y_SIZE; c++) begin
            b1[c] = biases[c];
            for (int i = 0; i < `FC_H_SIZE; i++) begin
                w1[c][i] = '0;
            end
        end
        load_net();
        run_net(exp);
    endtask

    // Even hidden neurons clip high, odd ones go negative and hit ReLU
    task automatic test_saturation();
        for (int i = 0; i < `FC_X0_SIZE; i++) begin
            x0[i] = 8'sd100;
        end
        for (int n = 0; n < `FC_H_SIZE; n++) begin
            b0[n] = '0;
            for (int i = 0; i < `FC_X0_SIZE; i++) begin
                w0[n][i] = (n % 2 == 1) ? -8'sd120 : 8'sd120;
            end
        end
        for (int c = 0; c < `FC_Y_SIZE; c++) begin
            b1[c] = '0;
            for (int i = 0; i < `FC_H_SIZE; i++) begin
                w1[c][i] = (i % 2 == 0) ? fc_pkg::int8_t'(3 * c - 4) : 8'sd50;
            end
        end
        load_net();
        run_net(model_class());
    endtask

    // Identical output rows give identical scores
    task automatic test_tie();
        randomize_net(3, 2);
        for (int c = 1; c < `FC_Y_SIZE; c++) begin
            b1[c] = b1[0];
            for (int i = 0; i < `FC_H_SIZE; i++) begin
                w1[c][i] = w1[0][i];
            end
        end
        load_net();
        run_net('0);
    endtask

    task automatic test_random();
        repeat (6) begin
            randomize_net(3, 2);
            load_net();
            run_net(model_class());
        end
    endtask

    task automatic test_double_start();
        logic           seen;
        fc_pkg::class_t got;
        randomize_net(3, 2);
        load_net();
        seen = 1'b0;
        got  = '0;
        pulse_start();
        repeat (8) begin
            @(negedge clk);
            check_flag("t_valid", t_valid, 1'b0);
        end
        // Second start lands while fetch is busy
        pulse_start();
        repeat (WINDOW) begin
            @(negedge clk);
            if (t_valid) begin
                if (seen) begin
                    fail_run("A second t_valid pulse followed the ignored start");
                end
                seen = 1'b1;
                got  = out_data;
            end
        end
        if (!seen) begin
            fail_run("No t_valid pulse arrived within the 400-cycle window");
        end
        check_class("out_data", got, model_class());
    endtask

    initial begin
        lfsr      = 32'h6773_15a6;
        rstn      = 1'b0;
        load_we   = 1'b0;
        load_sel  = 1'b0;
        load_addr = '0;
        load_data = '0;
        r_valid   = 1'b0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;

        test_idle();
        // Largest layer-1 bias placed in each lane in turn
        test_bias_only(32'h4D_05_0C_E2, 4'd3);
        test_bias_only(32'h62_9C_63_28, 4'd1);
        test_bias_only(32'h3B_3C_FF_00, 4'd2);
        test_bias_only(32'h80_FC_A6_FD, 4'd0);
        test_saturation();
        test_tie();
        test_random();
        test_double_start();

        $display("TEST OK");
        $finish;
    end

endmodule

//--- sources.f
+incdir+source
+incdir+tb
source/fc_pkg.sv
source/fc_if.sv
source/sync_ram.sv
source/fc_fetch.sv
source/fc_mac.sv
source/fc_result_sink.sv
source/fc_top.sv
tb/tb_fc_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_fc_top -o tb_fc_top
./obj_dir/tb_fc_top 2>&1 | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
